/* filelist.f */
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/rv_decoder.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/id_exe_reg.sv
rtl/execute_stage.sv
rtl/core_top.sv
bench/core_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := core_tb
FILELIST := filelist.f

BIN  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

/* bench/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    localparam int CW          = 64;
    localparam int MAX_PROG    = 16;
    localparam int NUM_TESTS   = 5;
    localparam int TOTAL_INSTR = 52;  // Sum of all program lengths
    localparam int WATCHDOG_NS = (TOTAL_INSTR * 4 + NUM_TESTS * 30) * 10;

    logic          clk;
    logic          reset;
    logic          id_valid;
    logic [31:0]   id_instr;
    logic [31:0]   id_pc;
    pipe_pkg::wb_t wb;
    logic          redirect_valid;
    logic [31:0]   redirect_pc;
    logic [CW-1:0] cycle_count;
    logic [CW-1:0] instret_count;

    logic [31:0] prog [0:MAX_PROG-1];  // Instruction memory, word indexed
    int          prog_len;
    logic [31:0] mregs [0:31];  // Reference register state
    logic [31:0] mpc;
    int          mretired;
    int          cycles;

    core_top #(
        .COUNTER_WIDTH (CW)
    ) u_dut (
        .clk            (clk),
        .reset          (reset),
        .id_valid       (id_valid),
        .id_instr       (id_instr),
        .id_pc          (id_pc),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .cycle_count    (cycle_count),
        .instret_count  (instret_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("TEST FAIL");
        $fatal(1);
    end

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s actual 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_instr(input logic [31:0] instr);
        prog[prog_len] = instr;
        prog_len++;
    endtask

    // Steps the ISA reference by one instruction and predicts wb and redirect
    task automatic model_step(input logic [31:0] ins, output logic wv, output logic [4:0] rd,
                              output logic [31:0] data, output logic rv,
                              output logic [31:0] tgt);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic        legal;
        logic        wr;
        logic        taken;
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        rd    = ins[11:7];
        legal = 1'b1;
        wr    = 1'b1;
        rv    = 1'b0;
        data  = '0;
        tgt   = '0;
        case (ins[6:0])
            7'b0110011: data = alu_ref(ins[14:12], ins[30], a, b);
            7'b0010011: data = alu_ref(ins[14:12], 1'b0, a, imm_i);
            7'b0110111: data = {ins[31:12], 12'b0};
            7'b0010111: data = mpc + {ins[31:12], 12'b0};
            7'b1101111: begin
                data = mpc + 32'd4;
                rv   = 1'b1;
                tgt  = mpc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                data = mpc + 32'd4;
                rv   = 1'b1;
                tgt  = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                case (ins[14:12])
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = $signed(a) < $signed(b);
                    default: taken = $signed(a) >= $signed(b);
                endcase
                rv  = taken;
                tgt = mpc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: legal = 1'b0;
        endcase
        wv = legal && wr && (rd != 5'd0);
        if (wv) mregs[rd] = data;
        if (legal) mretired++;
        mpc = rv ? tgt : mpc + 32'd4;
    endtask

    // Resets the DUT, acts as fetch and compares every EXE cycle with the model
    task automatic run_program();
        logic [31:0] fpc;
        logic        fetched;
        logic [31:0] fetched_pc;
        logic        slot_vld;
        logic [31:0] slot_pc;
        logic        wv;
        logic        rv;
        logic [4:0]  erd;
        logic [31:0] edata;
        logic [31:0] etgt;
        @(posedge clk);
        #1;
        reset    = 1'b1;
        id_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check("cycle_count", cycle_count, 64'd0);
        check("instret_count", instret_count, 64'd0);
        cycles   = 0;
        mpc      = '0;
        mretired = 0;
        for (int i = 0; i < 32; i++) mregs[i] = '0;
        fpc      = '0;
        slot_vld = 1'b0;
        slot_pc  = '0;
        do begin
            fetched    = fpc < 32'(prog_len * 4);
            fetched_pc = fpc;
            id_valid   = fetched;
            id_pc      = fpc;
            id_instr   = fetched ? prog[fpc[31:2]] : 32'h0000_0013;
            @(negedge clk);
            check("cycle_count", cycle_count, 64'(cycles));
            if (slot_vld) begin
                check("exe_pc", 64'(slot_pc), 64'(mpc));
                model_step(prog[slot_pc[31:2]], wv, erd, edata, rv, etgt);
                check("wb.valid", 64'(wb.valid), 64'(wv));
                if (wv) begin
                    check("wb.rd", 64'(wb.rd), 64'(erd));
                    check("wb.data", 64'(wb.data), 64'(edata));
                end
                check("redirect_valid", 64'(redirect_valid), 64'(rv));
                if (rv) check("redirect_pc", 64'(redirect_pc), 64'(etgt));
            end else begin
                check("wb.valid", 64'(wb.valid), 64'd0);
                check("redirect_valid", 64'(redirect_valid), 64'd0);
            end
            if (redirect_valid) begin
                fpc      = redirect_pc;
                slot_vld = 1'b0;  // Instruction in ID is flushed
            end else begin
                slot_vld = fetched;
                slot_pc  = fetched_pc;
                if (fetched) fpc = fpc + 32'd4;
            end
            @(posedge clk);
            cycles++;
            #1;
        end while (fpc < 32'(prog_len * 4) || slot_vld);
        id_valid = 1'b0;
        check("instret_count", instret_count, 64'(mretired));
        check("cycle_count", cycle_count, 64'(cycles));
    endtask

    task automatic alu_ops();
        prog_len = 0;
        add_instr(u_type(20'($urandom), 5'd1, 7'b0110111));
        add_instr(i_type(12'($urandom), 5'd1, 3'b000, 5'd1, 7'b0010011));
        add_instr(i_type(12'($urandom), 5'd0, 3'b000, 5'd2, 7'b0010011));
        add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        add_instr(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        add_instr(r_type(7'h00, 5'd4, 5'd3, 3'b111, 5'd5));
        add_instr(r_type(7'h00, 5'd4, 5'd3, 3'b110, 5'd6));
        add_instr(r_type(7'h00, 5'd6, 5'd5, 3'b100, 5'd7));
        add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
        add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd9));
        add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd10));
        add_instr(i_type(12'($urandom), 5'd1, 3'b111, 5'd11, 7'b0010011));
        add_instr(i_type(12'($urandom), 5'd1, 3'b110, 5'd12, 7'b0010011));
        add_instr(i_type(12'($urandom), 5'd1, 3'b100, 5'd13, 7'b0010011));
        add_instr(i_type(12'($urandom), 5'd1, 3'b010, 5'd14, 7'b0010011));
        add_instr(u_type(20'($urandom), 5'd15, 7'b0010111));
        run_program();
    endtask

    // Each instruction consumes the result of the one right before it
    task automatic bypass_chain();
        prog_len = 0;
        add_instr(i_type(12'($urandom), 5'd0, 3'b000, 5'd1, 7'b0010011));
        add_instr(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd1));
        add_instr(r_type(7'h20, 5'd0, 5'd1, 3'b000, 5'd2));
        add_instr(r_type(7'h00, 5'd1, 5'd2, 3'b100, 5'd2));
        add_instr(r_type(7'h00, 5'd2, 5'd2, 3'b000, 5'd3));
        add_instr(r_type(7'h00, 5'd1, 5'd3, 3'b010, 5'd4));
        run_program();
    endtask

    task automatic branches();
        prog_len = 0;
        add_instr(i_type(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
        add_instr(i_type(12'd5, 5'd0, 3'b000, 5'd2, 7'b0010011));
        add_instr(b_type(13'd8, 5'd2, 5'd1, 3'b000));   // beq taken
        add_instr(i_type(12'd1, 5'd0, 3'b000, 5'd3, 7'b0010011));
        add_instr(b_type(13'd8, 5'd2, 5'd1, 3'b001));   // bne falls through
        add_instr(i_type(12'd2, 5'd0, 3'b000, 5'd4, 7'b0010011));
        add_instr(i_type(12'hfff, 5'd0, 3'b000, 5'd5, 7'b0010011));
        add_instr(b_type(13'd12, 5'd1, 5'd5, 3'b100));  // blt taken as -1 < 5 signed
        add_instr(i_type(12'd6, 5'd0, 3'b000, 5'd6, 7'b0010011));
        add_instr(i_type(12'd7, 5'd0, 3'b000, 5'd7, 7'b0010011));
        add_instr(b_type(13'd8, 5'd5, 5'd1, 3'b101));
        add_instr(i_type(12'd8, 5'd0, 3'b000, 5'd8, 7'b0010011));
        add_instr(i_type(12'd3, 5'd0, 3'b000, 5'd9, 7'b0010011));
        run_program();
    endtask

    task automatic jumps();
        prog_len = 0;
        add_instr(j_type(21'd8, 5'd1));
        add_instr(i_type(12'd9, 5'd0, 3'b000, 5'd2, 7'b0010011));
        add_instr(i_type(12'd21, 5'd0, 3'b000, 5'd3, 7'b0010011));  // Odd target
        add_instr(i_type(12'd0, 5'd3, 3'b000, 5'd4, 7'b1100111));
        add_instr(i_type(12'd9, 5'd0, 3'b000, 5'd2, 7'b0010011));
        add_instr(r_type(7'h00, 5'd4, 5'd1, 3'b000, 5'd5));
        add_instr(j_type(21'd8, 5'd0));
        add_instr(i_type(12'd9, 5'd0, 3'b000, 5'd2, 7'b0010011));
        add_instr(i_type(12'd7, 5'd0, 3'b000, 5'd6, 7'b0010011));
        run_program();
    endtask

    task automatic x0_and_illegal();
        prog_len = 0;
        add_instr(i_type(12'($urandom), 5'd0, 3'b000, 5'd0, 7'b0010011));
        add_instr(32'h0000_007f);
        add_instr(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
        add_instr(i_type(12'($urandom), 5'd1, 3'b110, 5'd0, 7'b0010011));
        add_instr(32'hffff_ffff);
        add_instr(i_type(12'($urandom), 5'd0, 3'b000, 5'd2, 7'b0010011));
        add_instr(r_type(7'h00, 5'd0, 5'd2, 3'b000, 5'd3));
        add_instr(u_type(20'($urandom), 5'd0, 7'b0110111));
        run_program();
    endtask

    initial begin
        void'($urandom(32'h48b48f6d));
        reset    = 1'b1;
        id_valid = 1'b0;
        id_instr = '0;
        id_pc    = '0;
        prog_len = 0;
        alu_ops();
        bypass_chain();
        branches();
        jumps();
        x0_and_illegal();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* rtl/core_top.sv */
`timescale 1ns/1ps

module core_top #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         id_valid,
    input  logic [31:0]                  id_instr,
    input  logic [rv_isa_pkg::XLEN-1:0]  id_pc,
    output pipe_pkg::wb_t                wb,
    output logic                         redirect_valid,
    output logic [rv_isa_pkg::XLEN-1:0]  redirect_pc,
    output logic [COUNTER_WIDTH-1:0]     cycle_count,
    output logic [COUNTER_WIDTH-1:0]     instret_count
);

    pipe_pkg::id_exe_t id_bundle;
    pipe_pkg::id_exe_t exe_bundle;
    logic flush;

    assign flush = redirect_valid;  // Drop the wrong-path instruction in ID

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .id_valid  (id_valid),
        .id_instr  (id_instr),
        .id_pc     (id_pc),
        .wb        (wb),
        .id_bundle (id_bundle)
    );

    id_exe_reg #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) u_id_exe (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .id_bundle     (id_bundle),
        .exe_bundle    (exe_bundle),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

    execute_stage u_execute (
        .exe_bundle     (exe_bundle),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  pipe_pkg::id_exe_t            exe_bundle,
    output pipe_pkg::wb_t                wb,
    output logic                         redirect_valid,
    output logic [rv_isa_pkg::XLEN-1:0]  redirect_pc
);

    logic [rv_isa_pkg::XLEN-1:0] op_a;
    logic [rv_isa_pkg::XLEN-1:0] op_b;
    logic [rv_isa_pkg::XLEN-1:0] alu_out;
    logic [rv_isa_pkg::XLEN-1:0] link_pc;
    logic [rv_isa_pkg::XLEN-1:0] jalr_sum;
    logic lt_signed;
    logic taken;

    assign op_a      = exe_bundle.pc_to_a ? exe_bundle.pc : exe_bundle.rs1_data;
    assign op_b      = exe_bundle.use_imm ? exe_bundle.imm : exe_bundle.rs2_data;
    assign lt_signed = $signed(op_a) < $signed(op_b);
    assign link_pc   = exe_bundle.pc + rv_isa_pkg::XLEN'(4);
    assign jalr_sum  = exe_bundle.rs1_data + exe_bundle.imm;

    always_comb begin
        case (exe_bundle.alu_op)
            pipe_pkg::ALU_ADD:    alu_out = op_a + op_b;
            pipe_pkg::ALU_SUB:    alu_out = op_a - op_b;
            pipe_pkg::ALU_AND:    alu_out = op_a & op_b;
            pipe_pkg::ALU_OR:     alu_out = op_a | op_b;
            pipe_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            pipe_pkg::ALU_SLT:    alu_out = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_signed};
            pipe_pkg::ALU_SLL:    alu_out = op_a << op_b[4:0];
            pipe_pkg::ALU_SRL:    alu_out = op_a >> op_b[4:0];
            pipe_pkg::ALU_PASS_B: alu_out = op_b;
            default:              alu_out = '0;
        endcase
    end

    // Branches compare rs1 against rs2, so operands are the raw register values here
    always_comb begin
        case (exe_bundle.funct3)
            rv_isa_pkg::F3_BEQ: taken = op_a == op_b;
            rv_isa_pkg::F3_BNE: taken = op_a != op_b;
            rv_isa_pkg::F3_BLT: taken = lt_signed;
            rv_isa_pkg::F3_BGE: taken = !lt_signed;
            default:            taken = 1'b0;  // Unsigned forms not supported
        endcase
    end

    always_comb begin
        redirect_valid = exe_bundle.valid
                       && ((exe_bundle.is_branch && taken) || exe_bundle.is_jal
                           || exe_bundle.is_jalr);
        if (exe_bundle.is_jalr) begin
            redirect_pc = {jalr_sum[rv_isa_pkg::XLEN-1:1], 1'b0};
        end else begin
            redirect_pc = exe_bundle.pc + exe_bundle.imm;
        end
    end

    always_comb begin
        wb.valid = exe_bundle.valid && exe_bundle.reg_write;
        wb.rd    = exe_bundle.rd;
        wb.data  = (exe_bundle.is_jal || exe_bundle.is_jalr) ? link_pc : alu_out;
    end

endmodule

/* rtl/id_exe_reg.sv */
`timescale 1ns/1ps

module id_exe_reg #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  pipe_pkg::id_exe_t         id_bundle,
    output pipe_pkg::id_exe_t         exe_bundle,
    output logic [COUNTER_WIDTH-1:0]  cycle_count,
    output logic [COUNTER_WIDTH-1:0]  instret_count
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exe_bundle <= '0;
        end else if (flush) begin
            exe_bundle <= '0;  // Wrong-path instruction becomes a bubble
        end else begin
            exe_bundle <= id_bundle;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle_count   <= '0;
            instret_count <= '0;
        end else begin
            cycle_count <= cycle_count + COUNTER_WIDTH'(1);
            // Whatever leaves EXE valid has retired
            if (exe_bundle.valid) begin
                instret_count <= instret_count + COUNTER_WIDTH'(1);
            end
        end
    end

    a_flush_bubble: assert property (@(posedge clk) disable iff (reset)
        flush |=> !exe_bundle.valid);

    // Only a real instruction in EXE may redirect
    a_flush_from_valid: assert property (@(posedge clk) disable iff (reset)
        flush |-> exe_bundle.valid);

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         id_valid,
    input  logic [31:0]                  id_instr,
    input  logic [rv_isa_pkg::XLEN-1:0]  id_pc,
    input  pipe_pkg::wb_t                wb,
    output pipe_pkg::id_exe_t            id_bundle
);

    pipe_pkg::id_exe_t ctrl;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [rv_isa_pkg::XLEN-1:0] rdata1;
    logic [rv_isa_pkg::XLEN-1:0] rdata2;
    logic fwd1;
    logic fwd2;

    rv_decoder u_decoder (
        .instr (id_instr),
        .ctrl  (ctrl),
        .rs1   (rs1),
        .rs2   (rs2)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs1    (rs1),
        .rs2    (rs2),
        .wr     (wb),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // The array only updates at the end of the EXE cycle
    assign fwd1 = wb.valid && (wb.rd == rs1) && (rs1 != 5'd0);
    assign fwd2 = wb.valid && (wb.rd == rs2) && (rs2 != 5'd0);

    always_comb begin
        id_bundle          = ctrl;
        id_bundle.valid    = id_valid && ctrl.valid;
        id_bundle.pc       = id_pc;
        id_bundle.rs1_data = fwd1 ? wb.data : rdata1;
        id_bundle.rs2_data = fwd2 ? wb.data : rdata2;
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [4:0]                   rs1,
    input  logic [4:0]                   rs2,
    input  pipe_pkg::wb_t                wr,
    output logic [rv_isa_pkg::XLEN-1:0]  rdata1,
    output logic [rv_isa_pkg::XLEN-1:0]  rdata2
);

    logic [rv_isa_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.rd != 5'd0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // x0 reads as zero
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  logic [31:0]        instr,
    output pipe_pkg::id_exe_t  ctrl,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2
);

    rv_isa_pkg::instr_t fields;
    logic [rv_isa_pkg::XLEN-1:0] imm_i;
    logic [rv_isa_pkg::XLEN-1:0] imm_b;
    logic [rv_isa_pkg::XLEN-1:0] imm_j;
    logic [rv_isa_pkg::XLEN-1:0] imm_u;
    logic alt;

    function automatic pipe_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: alu_sel = sub ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     alu_sel = pipe_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     alu_sel = pipe_pkg::ALU_SLT;
            rv_isa_pkg::F3_XOR:     alu_sel = pipe_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL:     alu_sel = pipe_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      alu_sel = pipe_pkg::ALU_OR;
            rv_isa_pkg::F3_AND:     alu_sel = pipe_pkg::ALU_AND;
            default:                alu_sel = pipe_pkg::ALU_ADD;  // sltu not supported
        endcase
    endfunction

    assign fields = instr;
    assign rs1    = fields.rs1;
    assign rs2    = fields.rs2;
    assign alt    = fields.funct7[5];  // instr[30]

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.rd     = fields.rd;
        ctrl.funct3 = fields.funct3;
        case (rv_isa_pkg::opcode_e'(fields.opcode))
            rv_isa_pkg::OPC_OP: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_sel(fields.funct3, alt);
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_i;
                ctrl.alu_op    = alu_sel(fields.funct3, 1'b0);  // No subi
            end
            rv_isa_pkg::OPC_LUI: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_u;
                ctrl.alu_op    = pipe_pkg::ALU_PASS_B;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.pc_to_a   = 1'b1;
                ctrl.imm       = imm_u;
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.imm       = imm_j;
            end
            rv_isa_pkg::OPC_JALR: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.is_jalr   = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_i;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                ctrl.valid     = 1'b1;
                ctrl.is_branch = 1'b1;
                ctrl.imm       = imm_b;
            end
            default: ;  // Illegal opcode stays a bubble
        endcase
        // Writes to x0 are not architectural
        ctrl.reg_write = ctrl.reg_write && (fields.rd != 5'd0);
    end

endmodule

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8  // LUI
    } alu_op_e;

    // Decoded instruction as it moves from ID into EXE
    typedef struct packed {
        logic                          valid;
        logic [rv_isa_pkg::XLEN-1:0]   pc;
        logic [rv_isa_pkg::XLEN-1:0]   rs1_data;
        logic [rv_isa_pkg::XLEN-1:0]   rs2_data;
        logic [rv_isa_pkg::XLEN-1:0]   imm;
        logic [4:0]                    rd;
        alu_op_e                       alu_op;
        logic                          use_imm;   // B from imm
        logic                          pc_to_a;   // A from pc
        logic                          reg_write;
        logic                          is_branch;
        logic                          is_jal;
        logic                          is_jalr;
        logic [2:0]                    funct3;
    } id_exe_t;

    // Result written back at the end of EXE
    typedef struct packed {
        logic                          valid;
        logic [4:0]                    rd;
        logic [rv_isa_pkg::XLEN-1:0]   data;
    } wb_t;

endpackage

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    parameter int XLEN = 32;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // ALU kinds for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch kinds
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // R-type field layout that all formats share for opcode, rd, rs1, rs2 and funct3
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

endpackage
